// ==== logic/core_settings.svh ====
// core-wide width and step macros, included by every package and module that sizes a word
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ------------------------------
// datapath sizing
// ------------------------------
`define WORD_W      32          // data and pc width
`define REG_ADDR_W  5           // general register address
`define REG_NUM     32          // general register count

// ------------------------------
// program counter
// ------------------------------
`define PC_STEP     4           // bytes per instruction, also scales branch offsets

`endif

// ==== logic/isa_pkg.sv ====
// instruction set encodings and field helpers, imported by the decoder, execute stage and tests
`include "core_settings.svh"

package isa_pkg;

    // ------------------------------
    // field layout
    // ------------------------------
    localparam int opcode_lsb = 26;     // opcode in [31:26]
    localparam int rd_lsb     = 21;     // rd in [25:21]
    localparam int ra_lsb     = 16;     // ra in [20:16]
    localparam int rb_lsb     = 11;     // rb in [15:11]
    localparam int imm_w      = 16;     // alui and jal immediate in [15:0]
    localparam int br_off_w   = 11;     // branch offset in [10:0], below rb
    localparam int funct_w    = 4;      // register ops, low bits

    typedef enum logic [5:0] {
        op_nop  = 6'd0,
        op_alu  = 6'd1,                 // rd = ra <funct> rb
        op_alui = 6'd2,                 // rd = ra + sext(imm)
        op_cmp  = 6'd3,                 // rd = cmp(ra, rb), kind in funct
        op_br   = 6'd4,                 // kind in low bits of rd field
        op_jal  = 6'd5                  // rd = pc + step
    } opcode_t;

    typedef enum logic [3:0] {
        alu_nop = 4'd0,
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        cmp_nop = 3'd0,                 // always false
        cmp_eq  = 3'd1,
        cmp_ne  = 3'd2,
        cmp_lt  = 3'd3,
        cmp_ltu = 3'd4,
        cmp_ge  = 3'd5,
        cmp_geu = 3'd6
    } cmp_op_t;

    function automatic opcode_t instr_opcode(input logic [`WORD_W-1:0] instr);
        return opcode_t'(instr[opcode_lsb +: 6]);
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] instr_rd(input logic [`WORD_W-1:0] instr);
        return instr[rd_lsb +: `REG_ADDR_W];
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] instr_ra(input logic [`WORD_W-1:0] instr);
        return instr[ra_lsb +: `REG_ADDR_W];
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] instr_rb(input logic [`WORD_W-1:0] instr);
        return instr[rb_lsb +: `REG_ADDR_W];
    endfunction

    function automatic logic [funct_w-1:0] instr_funct(input logic [`WORD_W-1:0] instr);
        return instr[funct_w-1:0];
    endfunction

    function automatic logic [`WORD_W-1:0] instr_imm(input logic [`WORD_W-1:0] instr);
        return {{(`WORD_W-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
    endfunction

    function automatic logic [`WORD_W-1:0] instr_br_off(input logic [`WORD_W-1:0] instr);
        return {{(`WORD_W-br_off_w){instr[br_off_w-1]}}, instr[br_off_w-1:0]};
    endfunction

    // undefined codes fall back to the never-true compare
    function automatic cmp_op_t cmp_decode(input logic [2:0] code);
        return (code == 3'd7) ? cmp_nop : cmp_op_t'(code);
    endfunction

endpackage

// ==== logic/pipe_pkg.sv ====
// pipeline payload types carried between stages, imported by the stage modules and the top
`include "core_settings.svh"

package pipe_pkg;
    import isa_pkg::*;

    typedef enum logic [1:0] {
        sel_alu  = 2'd0,
        sel_cmp  = 2'd1,
        sel_link = 2'd2
    } wb_sel_t;

    // ------------------------------
    // decode to execute, zero is a bubble
    // ------------------------------
    typedef struct packed {
        alu_op_t                alu_op;
        logic [`WORD_W-1:0]     alu_in_0;
        logic [`WORD_W-1:0]     alu_in_1;
        cmp_op_t                cmp_op;
        logic [`WORD_W-1:0]     cmp_in_0;
        logic [`WORD_W-1:0]     cmp_in_1;
        logic [`REG_ADDR_W-1:0] ra_addr;
        logic [`REG_ADDR_W-1:0] rb_addr;
        logic                   alu_fwd_0;  // alu_in_0 read from ra
        logic                   alu_fwd_1;  // alu_in_1 read from rb
        logic                   cmp_fwd_0;  // cmp_in_0 read from ra
        logic                   cmp_fwd_1;  // cmp_in_1 read from rb
        logic                   jump;       // unconditional, jal
        logic                   branch;     // conditional on compare flag
        logic [`WORD_W-1:0]     br_target;
        logic [`REG_ADDR_W-1:0] dst_addr;
        logic                   gpr_we;
        wb_sel_t                wb_sel;
        logic [`WORD_W-1:0]     link_data;
    } id_ex_t;

    // ------------------------------
    // execute to writeback
    // ------------------------------
    typedef struct packed {
        logic [`WORD_W-1:0]     alu_out;
        logic                   cmp_flag;
        logic [`WORD_W-1:0]     link_data;
        logic [`REG_ADDR_W-1:0] dst_addr;
        logic                   gpr_we;
        wb_sel_t                wb_sel;
    } ex_wb_t;

endpackage

// ==== logic/gpr_file.sv ====
// general register file with two combinational read ports, one write port and r0 held at zero
`timescale 1ns/1ps
`include "core_settings.svh"

module gpr_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`REG_ADDR_W-1:0] rd_addr_b,
    output logic [`WORD_W-1:0]     rd_data_a,
    output logic [`WORD_W-1:0]     rd_data_b,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`WORD_W-1:0]     wr_data
);

    logic [`WORD_W-1:0] regs [`REG_NUM];
    logic               wr_live;            // a real write this cycle

    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so decode sees the instruction two ahead
    assign rd_data_a = (wr_live && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_live && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule

// ==== logic/stage_reg.sv ====
// pipeline stage register for any payload type, holds on stall and loads a bubble on flush
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_en,
    input  payload_t in_data,
    output logic     out_en,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_en   <= 1'b0;
            out_data <= '0;
        end else if (!stall) begin          // stall wins over flush
            if (flush) begin
                out_en   <= 1'b0;
                out_data <= '0;             // zero payload is a bubble
            end else begin
                out_en   <= in_en;
                out_data <= in_data;
            end
        end
    end

endmodule

// ==== logic/id_stage.sv ====
// decode stage, turns one instruction and its pc into the ID/EX payload using register reads
`timescale 1ns/1ps
`include "core_settings.svh"

module id_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic [`WORD_W-1:0]     instr,
    input  logic [`WORD_W-1:0]     pc,
    output logic [`REG_ADDR_W-1:0] gpr_addr_a,
    output logic [`REG_ADDR_W-1:0] gpr_addr_b,
    input  logic [`WORD_W-1:0]     gpr_data_a,
    input  logic [`WORD_W-1:0]     gpr_data_b,
    output id_ex_t                 id_out
);

    opcode_t              opcode;
    logic [funct_w-1:0]   funct;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`WORD_W-1:0]   imm_sx;
    logic [`WORD_W-1:0]   br_off_sx;

    assign opcode     = instr_opcode(instr);
    assign funct      = instr_funct(instr);
    assign rd         = instr_rd(instr);
    assign imm_sx     = instr_imm(instr);
    assign br_off_sx  = instr_br_off(instr);
    assign gpr_addr_a = instr_ra(instr);
    assign gpr_addr_b = instr_rb(instr);

    always_comb begin
        id_out           = '0;              // bubble unless decoded below
        id_out.ra_addr   = gpr_addr_a;
        id_out.rb_addr   = gpr_addr_b;
        id_out.dst_addr  = rd;
        id_out.link_data = pc + `WORD_W'(`PC_STEP);

        case (opcode)
            op_alu: begin
                id_out.alu_op    = funct[3] ? alu_nop : alu_op_t'(funct);
                id_out.alu_in_0  = gpr_data_a;
                id_out.alu_in_1  = gpr_data_b;
                id_out.alu_fwd_0 = 1'b1;
                id_out.alu_fwd_1 = 1'b1;
                id_out.gpr_we    = 1'b1;
                id_out.wb_sel    = sel_alu;
            end
            op_alui: begin
                id_out.alu_op    = alu_add;
                id_out.alu_in_0  = gpr_data_a;
                id_out.alu_in_1  = imm_sx;  // rb field is immediate here
                id_out.alu_fwd_0 = 1'b1;
                id_out.gpr_we    = 1'b1;
                id_out.wb_sel    = sel_alu;
            end
            op_cmp: begin
                id_out.cmp_op    = cmp_decode(funct[2:0]);
                id_out.cmp_in_0  = gpr_data_a;
                id_out.cmp_in_1  = gpr_data_b;
                id_out.cmp_fwd_0 = 1'b1;
                id_out.cmp_fwd_1 = 1'b1;
                id_out.gpr_we    = 1'b1;
                id_out.wb_sel    = sel_cmp;
            end
            op_br: begin
                id_out.cmp_op    = cmp_decode(rd[2:0]);  // kind lives in rd field
                id_out.cmp_in_0  = gpr_data_a;
                id_out.cmp_in_1  = gpr_data_b;
                id_out.cmp_fwd_0 = 1'b1;
                id_out.cmp_fwd_1 = 1'b1;
                id_out.branch    = 1'b1;
                id_out.br_target = pc + br_off_sx * `WORD_W'(`PC_STEP);
                id_out.gpr_we    = 1'b0;
            end
            op_jal: begin
                id_out.jump      = 1'b1;
                id_out.br_target = pc + imm_sx * `WORD_W'(`PC_STEP);
                id_out.gpr_we    = 1'b1;
                id_out.wb_sel    = sel_link;
            end
            default: begin
                id_out.dst_addr  = '0;      // op_nop and unknown opcodes
            end
        endcase
    end

endmodule

// ==== logic/ex_stage.sv ====
// execute stage with writeback forwarding, ALU, comparator and branch resolution
`timescale 1ns/1ps
`include "core_settings.svh"

module ex_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                   stall,
    input  logic                   id_en,
    input  id_ex_t                 id_data,
    input  logic                   fwd_en,
    input  logic [`REG_ADDR_W-1:0] fwd_addr,
    input  logic [`WORD_W-1:0]     fwd_data,
    output logic                   jump_taken,
    output logic [`WORD_W-1:0]     jump_target,
    output logic                   ex_en,
    output ex_wb_t                 ex_out
);

    logic               hit_a;
    logic               hit_b;
    logic [`WORD_W-1:0] alu_a;
    logic [`WORD_W-1:0] alu_b;
    logic [`WORD_W-1:0] cmp_a;
    logic [`WORD_W-1:0] cmp_b;
    logic [`WORD_W-1:0] alu_out;
    logic               cmp_flag;

    // ------------------------------
    // forwarding from writeback
    // ------------------------------
    assign hit_a = fwd_en && (fwd_addr == id_data.ra_addr);
    assign hit_b = fwd_en && (fwd_addr == id_data.rb_addr);

    assign alu_a = (id_data.alu_fwd_0 && hit_a) ? fwd_data : id_data.alu_in_0;
    assign alu_b = (id_data.alu_fwd_1 && hit_b) ? fwd_data : id_data.alu_in_1;
    assign cmp_a = (id_data.cmp_fwd_0 && hit_a) ? fwd_data : id_data.cmp_in_0;
    assign cmp_b = (id_data.cmp_fwd_1 && hit_b) ? fwd_data : id_data.cmp_in_1;

    // ------------------------------
    // ALU and comparator
    // ------------------------------
    always_comb begin
        case (id_data.alu_op)
            alu_add: alu_out = alu_a + alu_b;
            alu_sub: alu_out = alu_a - alu_b;
            alu_and: alu_out = alu_a & alu_b;
            alu_or:  alu_out = alu_a | alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];   // low 5 bits only
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (id_data.cmp_op)
            cmp_eq:  cmp_flag = (cmp_a == cmp_b);
            cmp_ne:  cmp_flag = (cmp_a != cmp_b);
            cmp_lt:  cmp_flag = ($signed(cmp_a) < $signed(cmp_b));
            cmp_ltu: cmp_flag = (cmp_a < cmp_b);
            cmp_ge:  cmp_flag = ($signed(cmp_a) >= $signed(cmp_b));
            cmp_geu: cmp_flag = (cmp_a >= cmp_b);
            default: cmp_flag = 1'b0;                 // nop never holds
        endcase
    end

    // one pulse per taken branch, held back while frozen
    assign jump_taken  = id_en && !stall && (id_data.jump || (id_data.branch && cmp_flag));
    assign jump_target = id_data.br_target;
    assign ex_en       = id_en;

    always_comb begin
        ex_out.alu_out   = alu_out;
        ex_out.cmp_flag  = cmp_flag;
        ex_out.link_data = id_data.link_data;
        ex_out.dst_addr  = id_data.dst_addr;
        ex_out.gpr_we    = id_data.gpr_we;
        ex_out.wb_sel    = id_data.wb_sel;
    end

endmodule

// ==== logic/wb_stage.sv ====
// writeback stage, selects the result, drives the register write, forward path and retire report
`timescale 1ns/1ps
`include "core_settings.svh"

module wb_stage
    import pipe_pkg::*;
(
    input  logic                   stall,
    input  logic                   wb_en,
    input  ex_wb_t                 wb_data,
    output logic                   gpr_wr_en,
    output logic [`REG_ADDR_W-1:0] gpr_wr_addr,
    output logic [`WORD_W-1:0]     gpr_wr_data,
    output logic                   fwd_en,
    output logic [`REG_ADDR_W-1:0] fwd_addr,
    output logic [`WORD_W-1:0]     fwd_data,
    output logic                   retire_en,
    output logic [`REG_ADDR_W-1:0] retire_addr,
    output logic [`WORD_W-1:0]     retire_data
);

    logic [`WORD_W-1:0] result;

    always_comb begin
        case (wb_data.wb_sel)
            sel_cmp:  result = {{(`WORD_W-1){1'b0}}, wb_data.cmp_flag};
            sel_link: result = wb_data.link_data;
            default:  result = wb_data.alu_out;
        endcase
    end

    // forward path stays live under stall, execute is frozen anyway
    assign fwd_en   = wb_en && wb_data.gpr_we && (wb_data.dst_addr != '0);
    assign fwd_addr = wb_data.dst_addr;
    assign fwd_data = result;

    assign gpr_wr_en   = fwd_en && !stall;
    assign gpr_wr_addr = wb_data.dst_addr;
    assign gpr_wr_data = result;

    assign retire_en   = gpr_wr_en;    // one report per committed write
    assign retire_addr = wb_data.dst_addr;
    assign retire_data = result;

endmodule

// ==== logic/pipe_core.sv ====
// top of the three-stage integer core, connects decode, execute, writeback and the register file
`timescale 1ns/1ps
`include "core_settings.svh"

module pipe_core
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`WORD_W-1:0]     instr,
    input  logic [`WORD_W-1:0]     pc,
    input  logic                   if_en,
    input  logic                   stall,
    output logic                   jump_taken,
    output logic [`WORD_W-1:0]     jump_target,
    output logic                   retire_en,
    output logic [`REG_ADDR_W-1:0] retire_addr,
    output logic [`WORD_W-1:0]     retire_data
);

    logic [`REG_ADDR_W-1:0] gpr_addr_a;
    logic [`REG_ADDR_W-1:0] gpr_addr_b;
    logic [`WORD_W-1:0]     gpr_data_a;
    logic [`WORD_W-1:0]     gpr_data_b;
    logic                   gpr_wr_en;
    logic [`REG_ADDR_W-1:0] gpr_wr_addr;
    logic [`WORD_W-1:0]     gpr_wr_data;
    id_ex_t                 id_out;
    logic                   id_en;
    id_ex_t                 id_data;
    logic                   ex_en;
    ex_wb_t                 ex_out;
    logic                   wb_en;
    ex_wb_t                 wb_data;
    logic                   fwd_en;
    logic [`REG_ADDR_W-1:0] fwd_addr;
    logic [`WORD_W-1:0]     fwd_data;

    gpr_file gpr_file_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (gpr_addr_a),
        .rd_addr_b (gpr_addr_b),
        .rd_data_a (gpr_data_a),
        .rd_data_b (gpr_data_b),
        .wr_en     (gpr_wr_en),
        .wr_addr   (gpr_wr_addr),
        .wr_data   (gpr_wr_data)
    );

    id_stage id_stage_inst (
        .instr      (instr),
        .pc         (pc),
        .gpr_addr_a (gpr_addr_a),
        .gpr_addr_b (gpr_addr_b),
        .gpr_data_a (gpr_data_a),
        .gpr_data_b (gpr_data_b),
        .id_out     (id_out)
    );

    // wrong-path instruction dropped by the taken-jump flush
    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall    (stall),
        .flush    (jump_taken),
        .in_en    (if_en),
        .in_data  (id_out),
        .out_en   (id_en),
        .out_data (id_data)
    );

    ex_stage ex_stage_inst (
        .stall       (stall),
        .id_en       (id_en),
        .id_data     (id_data),
        .fwd_en      (fwd_en),
        .fwd_addr    (fwd_addr),
        .fwd_data    (fwd_data),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .ex_en       (ex_en),
        .ex_out      (ex_out)
    );

    stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall    (stall),
        .flush    (1'b0),           // nothing behind a branch to squash
        .in_en    (ex_en),
        .in_data  (ex_out),
        .out_en   (wb_en),
        .out_data (wb_data)
    );

    wb_stage wb_stage_inst (
        .stall       (stall),
        .wb_en       (wb_en),
        .wb_data     (wb_data),
        .gpr_wr_en   (gpr_wr_en),
        .gpr_wr_addr (gpr_wr_addr),
        .gpr_wr_data (gpr_wr_data),
        .fwd_en      (fwd_en),
        .fwd_addr    (fwd_addr),
        .fwd_data    (fwd_data),
        .retire_en   (retire_en),
        .retire_addr (retire_addr),
        .retire_data (retire_data)
    );

endmodule

// ==== test/pipe_core_model.svh ====
// reference model and instruction encoder, included inside the core testbench module
`ifndef PIPE_CORE_MODEL_SVH
`define PIPE_CORE_MODEL_SVH

`include "core_settings.svh"

typedef struct packed {
    logic [`REG_ADDR_W-1:0] addr;
    logic [`WORD_W-1:0]     data;
} wr_rec_t;

logic [`WORD_W-1:0] model_regs [`REG_NUM];     // architectural state, r0 never written
wr_rec_t            exp_wr_q [$];               // writes in retire order
logic [`WORD_W-1:0] exp_jump_q [$];             // targets of taken jumps in order

// ------------------------------
// instruction encoder
// ------------------------------
function automatic logic [`WORD_W-1:0] reg_op_word(input opcode_t op, input int rd,
                                                   input int ra, input int rb, input int funct);
    return {op, 5'(rd), 5'(ra), 5'(rb), 7'b0, 4'(funct)};
endfunction

function automatic logic [`WORD_W-1:0] imm_op_word(input opcode_t op, input int rd,
                                                   input int ra, input logic [15:0] imm);
    return {op, 5'(rd), 5'(ra), imm};
endfunction

// compare kind sits in the rd field, offset in the low 11 bits
function automatic logic [`WORD_W-1:0] branch_word(input int kind, input int ra,
                                                   input int rb, input int off);
    return {op_br, 5'(kind), 5'(ra), 5'(rb), 11'(off)};
endfunction

function automatic logic [`WORD_W-1:0] nop_word();
    return {op_nop, 26'b0};
endfunction

// ------------------------------
// execution rules
// ------------------------------
function automatic logic [`WORD_W-1:0] alu_result(input logic [3:0] funct,
                                                  input logic [`WORD_W-1:0] a,
                                                  input logic [`WORD_W-1:0] b);
    case (funct)
        alu_add: return a + b;
        alu_sub: return a - b;
        alu_and: return a & b;
        alu_or:  return a | b;
        alu_xor: return a ^ b;
        alu_sll: return a << b[4:0];            // shift by low 5 bits
        alu_srl: return a >> b[4:0];
        default: return '0;
    endcase
endfunction

function automatic logic compare_flag(input logic [2:0] kind, input logic [`WORD_W-1:0] a,
                                      input logic [`WORD_W-1:0] b);
    case (kind)
        cmp_eq:  return a == b;
        cmp_ne:  return a != b;
        cmp_lt:  return $signed(a) < $signed(b);
        cmp_ltu: return a < b;
        cmp_ge:  return $signed(a) >= $signed(b);
        cmp_geu: return a >= b;
        default: return 1'b0;                   // nop and unused codes
    endcase
endfunction

task automatic commit_write(input logic [`REG_ADDR_W-1:0] rd, input logic [`WORD_W-1:0] data);
    wr_rec_t rec;
    if (rd != '0) begin
        model_regs[rd] = data;
        rec.addr = rd;
        rec.data = data;
        exp_wr_q.push_back(rec);
    end
endtask

// runs one accepted instruction in program order
task automatic execute_instr(input logic [`WORD_W-1:0] ins, input logic [`WORD_W-1:0] ins_pc,
                             output logic taken, output logic [`WORD_W-1:0] target);
    logic [`REG_ADDR_W-1:0] rd;
    logic [`WORD_W-1:0]     a;
    logic [`WORD_W-1:0]     b;
    logic [`WORD_W-1:0]     imm16;
    logic [`WORD_W-1:0]     off11;
    rd     = ins[25:21];
    a      = model_regs[ins[20:16]];
    b      = model_regs[ins[15:11]];
    imm16  = {{(`WORD_W-16){ins[15]}}, ins[15:0]};
    off11  = {{(`WORD_W-11){ins[10]}}, ins[10:0]};
    taken  = 1'b0;
    target = '0;
    case (ins[31:26])
        op_alu:  commit_write(rd, alu_result(ins[3:0], a, b));
        op_alui: commit_write(rd, a + imm16);
        op_cmp:  commit_write(rd, {{(`WORD_W-1){1'b0}}, compare_flag(ins[2:0], a, b)});
        op_br: begin
            taken  = compare_flag(rd[2:0], a, b);
            target = ins_pc + off11 * `PC_STEP;
        end
        op_jal: begin
            commit_write(rd, ins_pc + `PC_STEP);
            taken  = 1'b1;
            target = ins_pc + imm16 * `PC_STEP;
        end
        default: ;
    endcase
    if (taken) begin
        exp_jump_q.push_back(target);
    end
endtask

`endif

// ==== test/pipe_core_tb.sv ====
// testbench for the core, runs directed and random programs with stalls and checks every retire
`timescale 1ns/1ps
`include "core_settings.svh"

module pipe_core_tb
    import isa_pkg::*;
();

    localparam int     n_directed  = 80;       // directed slots, rounded up
    localparam int     n_random    = 400;
    localparam longint watchdog_ns = longint'(n_directed + n_random) * 10 * 40;

    `include "pipe_core_model.svh"

    logic                   clk = 1'b1;
    logic                   arst_n = 1'b1;
    logic [`WORD_W-1:0]     instr;
    logic [`WORD_W-1:0]     pc;
    logic                   if_en;
    logic                   stall;
    logic                   jump_taken;
    logic [`WORD_W-1:0]     jump_target;
    logic                   retire_en;
    logic [`REG_ADDR_W-1:0] retire_addr;
    logic [`WORD_W-1:0]     retire_data;

    logic [`WORD_W-1:0]     next_pc;            // pc of the next presented instruction
    logic                   flush_due;          // taken jump waiting in execute
    logic [`WORD_W-1:0]     flush_target;
    wr_rec_t                head_wr;
    logic [`WORD_W-1:0]     head_jump;
    int                     stall_left;

    pipe_core pipe_core_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .pc          (pc),
        .if_en       (if_en),
        .stall       (stall),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .retire_en   (retire_en),
        .retire_addr (retire_addr),
        .retire_data (retire_data)
    );

    always #20 clk = ~clk;

    task automatic abort_on_mismatch(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic run_cycle(input logic hold_in, input logic valid_in,
                             input logic [`WORD_W-1:0] word);
        logic               taken;
        logic [`WORD_W-1:0] target;
        stall = hold_in;
        if_en = valid_in;
        instr = word;
        pc    = next_pc;
        if (!hold_in) begin
            if (flush_due) begin
                flush_due = 1'b0;               // word is on the wrong path
                next_pc   = flush_target;
            end else if (valid_in) begin
                execute_instr(word, next_pc, taken, target);
                next_pc = next_pc + `PC_STEP;
                if (taken) begin
                    flush_due    = 1'b1;
                    flush_target = target;
                end
            end
        end
        @(negedge clk);
    endtask

    task automatic issue(input logic [`WORD_W-1:0] word);
        run_cycle(1'b0, 1'b1, word);
    endtask

    task automatic hold(input logic [`WORD_W-1:0] word);
        run_cycle(1'b1, 1'b1, word);
    endtask

    task automatic bubble();
        run_cycle(1'b0, 1'b0, nop_word());
    endtask

    function automatic logic [`WORD_W-1:0] random_instr();
        int kind;
        kind = $urandom_range(9);
        case (kind)
            0, 1, 2: return reg_op_word(op_alu, $urandom_range(15), $urandom_range(15),
                                        $urandom_range(15), $urandom_range(7));
            3, 4:    return imm_op_word(op_alui, $urandom_range(15), $urandom_range(15),
                                        16'($urandom));
            5, 6:    return reg_op_word(op_cmp, $urandom_range(15), $urandom_range(15),
                                        $urandom_range(15), $urandom_range(7));
            7:       return branch_word($urandom_range(7), $urandom_range(15),
                                        $urandom_range(15), $urandom_range(2047));
            8:       return imm_op_word(op_jal, $urandom_range(15), 0, 16'($urandom));
            default: return nop_word();
        endcase
    endfunction

    initial begin
        void'($urandom(88443));
        stall        = 1'b0;
        if_en        = 1'b0;
        instr        = '0;
        pc           = '0;
        next_pc      = '0;
        flush_due    = 1'b0;
        flush_target = '0;
        stall_left   = 0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        @(negedge clk);
        arst_n = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        bubble();
        bubble();

        // ALU and immediate ops, back-to-back and distance-two dependencies
        issue(imm_op_word(op_alui, 1, 0, 16'h1234));
        issue(imm_op_word(op_alui, 2, 0, 16'hfff0));
        issue(reg_op_word(op_alu, 3, 1, 2, alu_add));
        issue(reg_op_word(op_alu, 4, 3, 1, alu_sub));
        issue(reg_op_word(op_alu, 5, 4, 3, alu_and));
        issue(reg_op_word(op_alu, 6, 1, 2, alu_or));
        issue(reg_op_word(op_alu, 7, 6, 1, alu_xor));
        issue(imm_op_word(op_alui, 8, 0, 16'd36));     // shift of 36 uses only 4
        issue(reg_op_word(op_alu, 9, 2, 8, alu_sll));
        issue(reg_op_word(op_alu, 10, 2, 8, alu_srl));
        issue(imm_op_word(op_alui, 11, 11, 16'd5));
        issue(imm_op_word(op_alui, 11, 11, 16'd5));

        // every compare kind, -16 against 0x1234 both ways
        for (int k = 0; k < 8; k++) begin
            issue(reg_op_word(op_cmp, 12, 2, 1, k));
            issue(reg_op_word(op_cmp, 12, 1, 2, k));
        end
        issue(reg_op_word(op_cmp, 13, 1, 1, cmp_eq));

        // r0 stays zero
        issue(imm_op_word(op_alui, 0, 1, 16'd7));
        issue(reg_op_word(op_alu, 14, 0, 1, alu_or));

        // ------------------------------
        // branches and jal
        // ------------------------------
        issue(branch_word(cmp_ne, 1, 2, 3));
        issue(imm_op_word(op_alui, 15, 0, 16'hdead));  // wrong path
        issue(branch_word(cmp_eq, 1, 2, 2));
        issue(imm_op_word(op_alui, 16, 0, 16'd1));
        issue(branch_word(cmp_lt, 2, 1, -2));
        issue(imm_op_word(op_alui, 15, 0, 16'hbeef));  // wrong path
        issue(imm_op_word(op_jal, 17, 0, 16'd8));
        issue(imm_op_word(op_alui, 15, 0, 16'hbad0));  // wrong path
        issue(reg_op_word(op_alu, 18, 17, 17, alu_add));
        issue(imm_op_word(op_alui, 19, 0, 16'd3));
        issue(branch_word(cmp_geu, 19, 2, 4));
        issue(branch_word(cmp_ge, 19, 2, 4));
        issue(imm_op_word(op_alui, 15, 0, 16'h0bad));  // wrong path

        // stall with a dependent pair in flight, then stall behind a taken branch
        issue(imm_op_word(op_alui, 20, 0, 16'd100));
        issue(reg_op_word(op_alu, 21, 20, 20, alu_add));
        hold(reg_op_word(op_alu, 22, 21, 20, alu_sub));
        hold(reg_op_word(op_alu, 22, 21, 20, alu_sub));
        issue(reg_op_word(op_alu, 22, 21, 20, alu_sub));
        issue(branch_word(cmp_ne, 20, 0, 2));
        hold(imm_op_word(op_alui, 15, 0, 16'h1111));
        hold(imm_op_word(op_alui, 15, 0, 16'h1111));
        issue(imm_op_word(op_alui, 15, 0, 16'h1111)); // wrong path
        issue(imm_op_word(op_alui, 23, 22, 16'd9));
        bubble();
        bubble();

        // random mix with stall pulses
        for (int n = 0; n < n_random; n++) begin
            if (stall_left == 0 && $urandom_range(11) == 0) begin
                stall_left = $urandom_range(4, 1);
            end
            if (stall_left > 0) begin
                stall_left--;
                run_cycle(1'b1, 1'b1, random_instr());
            end else begin
                run_cycle(1'b0, ($urandom_range(4) != 0), random_instr());
            end
        end

        repeat (4) bubble();                            // drain the pipe and catch stray retires
        if (exp_wr_q.size() == 0 && exp_jump_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Expected writes or jumps never showed up at the outputs");
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // ------------------------------
    // checking
    // ------------------------------
    always @(posedge clk) begin
        if (!arst_n) begin
            assert (!jump_taken && !retire_en)
                else abort_on_mismatch($sformatf("in reset expected 0/0, got jump %b retire %b",
                                                 jump_taken, retire_en));
        end else begin
            assert (!(stall && (jump_taken || retire_en)))
                else abort_on_mismatch("expected no jump or retire under stall, got one");
            if (retire_en) begin
                assert (exp_wr_q.size() != 0)
                    else abort_on_mismatch($sformatf("expected no retire, got r%0d=%h",
                                                     retire_addr, retire_data));
                head_wr = exp_wr_q.pop_front();
                assert (retire_addr == head_wr.addr && retire_data == head_wr.data)
                    else abort_on_mismatch($sformatf("expected retire r%0d=%h, got r%0d=%h",
                                                     head_wr.addr, head_wr.data,
                                                     retire_addr, retire_data));
            end
            if (jump_taken) begin
                assert (exp_jump_q.size() != 0)
                    else abort_on_mismatch($sformatf("expected no jump, got target %h",
                                                     jump_target));
                head_jump = exp_jump_q.pop_front();
                assert (jump_target == head_jump)
                    else abort_on_mismatch($sformatf("expected jump target %h, got %h",
                                                     head_jump, jump_target));
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, the pipeline stopped making progress");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

// ==== pipe_core.f ====
+incdir+logic
+incdir+test
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/gpr_file.sv
logic/stage_reg.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/wb_stage.sv
logic/pipe_core.sv
test/pipe_core_tb.sv
